/* flist.f */
verilog/ddr3_pkg.sv
verilog/ddr3_scheduler.sv
verilog/sync_fifo.sv
verilog/ddr3_cmd_timer.sv
verilog/ddr3_ctrl_top.sv
verification/tb_clock_gen.sv
verification/tb_ddr3_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the DDR3 scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_ddr3_ctrl -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verification/ddr3_cases.txt */
# kind addr tid: R read, W write (tid is the expected write id), F refresh (addr, tid unused)
# a B line is a read raised in the same cycle as the W line after it
B 001490 3
W 0014B0 0
R 0014A0 4
W 048C81 1
R 7FFFFF F
F 000000 0
R 048C82 5
B 010105 6
W 010106 2
B 010108 7
W 01010A 3
W 00A00C 4
R 00A30D 8
R 00E30D 9
F 000000 0
F 000000 0
W 00E30E 5
B 00E310 A
W 00A00C 6
R 1FFC05 B
W 1FFC06 7

/* verification/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  initial begin
    clock_o = 1'b0;
    forever #5 clock_o = ~clock_o;
  end

  // reset held for the first 10 rising edges
  initial begin
    reset_o = 1'b1;
    repeat (10) @(posedge clock_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

/* verification/tb_ddr3_ctrl.sv */
`default_nettype none

module tb_ddr3_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  import ddr3_pkg::*;

  // one expected command on the pins
  typedef struct packed {
    ddr3_cmd_e             cmd;
    logic [BANK_BITS-1:0]  ba;
    logic [ROW_BITS-1:0]   adr;
    logic [TID_BITS-1:0]   tid;
    int                    case_no;
    logic                  last;
  } exp_entry_t;

  logic                 clock;
  logic                 reset;
  logic                 mem_wrreq_i;
  logic [ADDR_BITS-1:0] mem_wradr_i;
  logic                 mem_wrack_o;
  logic [TID_BITS-1:0]  mem_wrtid_o;
  logic                 mem_rdreq_i;
  logic [ADDR_BITS-1:0] mem_rdadr_i;
  logic [TID_BITS-1:0]  mem_rdtid_i;
  logic                 mem_rdack_o;
  logic                 ref_tick_i;
  logic                 ddr_cmd_valid_o;
  ddr3_cmd_e            ddr_cmd_o;
  logic [BANK_BITS-1:0] ddr_ba_o;
  logic [ROW_BITS-1:0]  ddr_adr_o;
  logic [TID_BITS-1:0]  ddr_tid_o;

  // cases as read from the file
  byte                  kinds [$];
  logic [ADDR_BITS-1:0] adrs [$];
  logic [TID_BITS-1:0]  tids [$];
  int                   num_cases = 0;

  exp_entry_t exp_q [$];

  // reference bank table
  logic                model_open [NUM_BANKS];
  logic [ROW_BITS-1:0] model_row [NUM_BANKS];
  logic                model_prefer_rd = 1'b1;

  int          errors = 0;
  int          checks = 0;
  int          cases_done = 0;
  int          cycle_cnt = 0;
  int          last_cycle = 0;
  logic        have_last = 1'b0;
  ddr3_cmd_e   last_cmd;
  logic [31:0] rng_state = 32'd36;

  tb_clock_gen u_clock_gen (
    .clock_o (clock),
    .reset_o (reset)
  );

  ddr3_ctrl_top dut (
    .clock           (clock),
    .reset           (reset),
    .mem_wrreq_i     (mem_wrreq_i),
    .mem_wradr_i     (mem_wradr_i),
    .mem_wrack_o     (mem_wrack_o),
    .mem_wrtid_o     (mem_wrtid_o),
    .mem_rdreq_i     (mem_rdreq_i),
    .mem_rdadr_i     (mem_rdadr_i),
    .mem_rdtid_i     (mem_rdtid_i),
    .mem_rdack_o     (mem_rdack_o),
    .ref_tick_i      (ref_tick_i),
    .ddr_cmd_valid_o (ddr_cmd_valid_o),
    .ddr_cmd_o       (ddr_cmd_o),
    .ddr_ba_o        (ddr_ba_o),
    .ddr_adr_o       (ddr_adr_o),
    .ddr_tid_o       (ddr_tid_o)
  );

  // lcg for the idle gaps between cases
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  // minimum idle cycles owed after each command
  function automatic int gap_of(input ddr3_cmd_e cmd);
    case (cmd)
      CMD_PREC: return T_RP;
      CMD_ACTV: return T_RCD;
      CMD_READ: return T_CCD;
      CMD_WRIT: return T_CCD;
      CMD_REFR: return T_RFC;
      default:  return 0;
    endcase
  endfunction

  task automatic check_cmd(input ddr3_cmd_e got, input ddr3_cmd_e exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_bank(input logic [BANK_BITS-1:0] got, input logic [BANK_BITS-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input logic [ROW_BITS-1:0] got, input logic [ROW_BITS-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  task automatic check_tid(input logic [TID_BITS-1:0] got, input logic [TID_BITS-1:0] exp,
                           input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // comment lines start with #
  task automatic load_cases();
    int                   fd;
    int                   n;
    string                line;
    byte                  k;
    logic [ADDR_BITS-1:0] a;
    logic [TID_BITS-1:0]  t;
    fd = $fopen("verification/ddr3_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the case file verification/ddr3_cases.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 3 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%c %h %h", k, a, t);
        if (n == 3) begin
          kinds.push_back(k);
          adrs.push_back(a);
          tids.push_back(t);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic expect_cmd(input ddr3_cmd_e cmd, input logic [BANK_BITS-1:0] ba,
                            input logic [ROW_BITS-1:0] adr, input logic [TID_BITS-1:0] tid,
                            input int case_no, input logic last);
    exp_entry_t e;
    e.cmd     = cmd;
    e.ba      = ba;
    e.adr     = adr;
    e.tid     = tid;
    e.case_no = case_no;
    e.last    = last;
    exp_q.push_back(e);
  endtask

  // row, bank, column from msb down
  task automatic model_request(input logic is_wr, input logic [ADDR_BITS-1:0] adr,
                               input logic [TID_BITS-1:0] tid, input int case_no);
    logic [ROW_BITS-1:0]  row;
    logic [BANK_BITS-1:0] bank;
    logic [COL_BITS-1:0]  col;
    row  = adr[ADDR_BITS-1 -: ROW_BITS];
    bank = adr[COL_BITS +: BANK_BITS];
    col  = adr[COL_BITS-1:0];
    // another row open in this bank
    if (model_open[bank] && model_row[bank] != row) begin
      expect_cmd(CMD_PREC, bank, '0, tid, case_no, 1'b0);
    end
    if (!model_open[bank] || model_row[bank] != row) begin
      expect_cmd(CMD_ACTV, bank, row, tid, case_no, 1'b0);
    end
    expect_cmd(is_wr ? CMD_WRIT : CMD_READ, bank, ROW_BITS'(col), tid, case_no, 1'b1);
    model_open[bank] = 1'b1;
    model_row[bank]  = row;
  endtask

  task automatic model_refresh(input int case_no);
    logic any_open;
    any_open = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      any_open = any_open | model_open[b];
    end
    // precharge all carries A10
    if (any_open) begin
      expect_cmd(CMD_PREC, '0, ROW_BITS'(1 << 10), '0, case_no, 1'b0);
    end
    expect_cmd(CMD_REFR, '0, '0, '0, case_no, 1'b1);
    for (int b = 0; b < NUM_BANKS; b++) begin
      model_open[b] = 1'b0;
    end
  endtask

  // four-phase handshake on the read port
  task automatic do_read(input logic [ADDR_BITS-1:0] adr, input logic [TID_BITS-1:0] tid);
    @(posedge clock);
    #1;
    check_flag(mem_rdack_o, 1'b0, "read ack before req");
    mem_rdreq_i = 1'b1;
    mem_rdadr_i = adr;
    mem_rdtid_i = tid;
    do begin
      @(posedge clock);
      #1;
    end while (!mem_rdack_o);
    mem_rdreq_i = 1'b0;
    @(posedge clock);
    #1;
    check_flag(mem_rdack_o, 1'b0, "read ack after req drop");
  endtask

  // write id must match while ack is high
  task automatic do_write(input logic [ADDR_BITS-1:0] adr, input logic [TID_BITS-1:0] exp_tid);
    @(posedge clock);
    #1;
    check_flag(mem_wrack_o, 1'b0, "write ack before req");
    mem_wrreq_i = 1'b1;
    mem_wradr_i = adr;
    do begin
      @(posedge clock);
      #1;
    end while (!mem_wrack_o);
    check_tid(mem_wrtid_o, exp_tid, "write id at ack");
    mem_wrreq_i = 1'b0;
    @(posedge clock);
    #1;
    check_flag(mem_wrack_o, 1'b0, "write ack after req drop");
  endtask

  task automatic do_refresh();
    @(posedge clock);
    #1;
    ref_tick_i = 1'b1;
    @(posedge clock);
    #1;
    ref_tick_i = 1'b0;
    // a second tick before REFR leaves the scheduler would merge
    while (exp_q.size() != 0) begin
      @(posedge clock);
    end
  endtask

  task automatic run_cases();
    int          i;
    logic [31:0] r;
    i = 0;
    while (i < num_cases) begin
      r = next_rand();
      repeat (int'(r[18:16])) @(posedge clock);
      if (kinds[i] == "F") begin
        model_refresh(i);
        do_refresh();
        i++;
      end else if (kinds[i] == "R") begin
        model_request(1'b0, adrs[i], tids[i], i);
        do_read(adrs[i], tids[i]);
        i++;
      end else if (kinds[i] == "W") begin
        model_request(1'b1, adrs[i], tids[i], i);
        do_write(adrs[i], tids[i]);
        i++;
      end else if (kinds[i] == "B" && i + 1 < num_cases && kinds[i+1] == "W") begin
        // contended pairs take turns on which port goes first
        if (model_prefer_rd) begin
          model_request(1'b0, adrs[i], tids[i], i);
          model_request(1'b1, adrs[i+1], tids[i+1], i + 1);
        end else begin
          model_request(1'b1, adrs[i+1], tids[i+1], i + 1);
          model_request(1'b0, adrs[i], tids[i], i);
        end
        model_prefer_rd = !model_prefer_rd;
        fork
          do_read(adrs[i], tids[i]);
          do_write(adrs[i+1], tids[i+1]);
        join
        i += 2;
      end else begin
        errors++;
        $display("case %0d has kind %c, which is unknown or lacks its write line", i + 1,
                 kinds[i]);
        i++;
      end
    end
  endtask

  // pins are stable at the falling edge
  always @(negedge clock) begin
    exp_entry_t e;
    if (!reset) begin
      cycle_cnt++;
      if (ddr_cmd_valid_o) begin
        if (have_last && (cycle_cnt - last_cycle - 1) < gap_of(last_cmd)) begin
          errors++;
          $display("Fail at %0t: %0d idle cycles after %s, at least %0d needed", $time,
                   cycle_cnt - last_cycle - 1, last_cmd.name(), gap_of(last_cmd));
        end
        have_last  = 1'b1;
        last_cycle = cycle_cnt;
        last_cmd   = ddr_cmd_o;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Fail at %0t: %s issued while no command was expected", $time,
                   ddr_cmd_o.name());
        end else begin
          e = exp_q.pop_front();
          check_cmd(ddr_cmd_o, e.cmd, "command");
          check_bank(ddr_ba_o, e.ba, "bank");
          check_addr(ddr_adr_o, e.adr, "address");
          check_tid(ddr_tid_o, e.tid, "tid");
          if (e.last) begin
            cases_done++;
            $display("case %0d (%c) done at %0t, %0d errors so far", e.case_no + 1,
                     kinds[e.case_no], $time, errors);
          end
        end
      end else begin
        check_cmd(ddr_cmd_o, CMD_NOOP, "idle command");
      end
    end
  end

  // 100 cycles per case
  initial begin
    wait (num_cases > 0);
    repeat (num_cases * 100) @(posedge clock);
    $display("timeout: the cases did not finish within %0d cycles", num_cases * 100);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    mem_wrreq_i = 1'b0;
    mem_wradr_i = '0;
    mem_rdreq_i = 1'b0;
    mem_rdadr_i = '0;
    mem_rdtid_i = '0;
    ref_tick_i  = 1'b0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      model_open[b] = 1'b0;
      model_row[b]  = '0;
    end
    load_cases();
    num_cases = kinds.size();
    @(negedge reset);
    // quiet after reset until a request comes
    repeat (5) begin
      @(posedge clock);
      #1;
      check_flag(ddr_cmd_valid_o, 1'b0, "command valid after reset");
      check_flag(mem_rdack_o, 1'b0, "read ack after reset");
      check_flag(mem_wrack_o, 1'b0, "write ack after reset");
    end
    run_cases();
    while (exp_q.size() != 0) begin
      @(posedge clock);
    end
    // room for any stray command
    repeat (30) @(posedge clock);
    $display("%0d of %0d cases done, %0d checks, %0d errors", cases_done, num_cases, checks,
             errors);
    if (errors == 0 && cases_done == num_cases && num_cases > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/ddr3_cmd_timer.sv */
`default_nettype none

module ddr3_cmd_timer (
  input  wire logic                          clock,
  input  wire logic                          reset,
  // queued commands
  input  wire logic                          q_valid_i,
  output logic                               q_ready_o,
  input  wire logic [ddr3_pkg::CMD_BITS-1:0] q_data_i,
  // memory command pins
  output logic                               ddr_cmd_valid_o,
  output ddr3_pkg::ddr3_cmd_e                ddr_cmd_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]     ddr_ba_o,
  output logic [ddr3_pkg::ROW_BITS-1:0]      ddr_adr_o,
  output logic [ddr3_pkg::TID_BITS-1:0]      ddr_tid_o
);

  import ddr3_pkg::*;

  logic [GAP_BITS-1:0] gap_cnt;
  logic [GAP_BITS-1:0] issued_gap;
  logic                pop;
  ddr3_cmd_e           q_op;

  assign q_op = ddr3_cmd_e'(q_data_i[OP_LSB +: OP_BITS]);

  // hold off while a command sits on the pins or its gap runs
  assign q_ready_o = (gap_cnt == '0) && !ddr_cmd_valid_o;
  assign pop       = q_valid_i && q_ready_o;

  // spacing owed to the command now on the pins
  always_comb begin
    case (ddr_cmd_o)
      CMD_PREC: issued_gap = GAP_BITS'(T_RP);
      CMD_ACTV: issued_gap = GAP_BITS'(T_RCD);
      CMD_READ: issued_gap = GAP_BITS'(T_CCD);
      CMD_WRIT: issued_gap = GAP_BITS'(T_CCD);
      CMD_REFR: issued_gap = GAP_BITS'(T_RFC);
      default:  issued_gap = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ddr_cmd_valid_o <= 1'b0;
      ddr_cmd_o       <= CMD_NOOP;
      gap_cnt         <= '0;
    end else begin
      // one-cycle pulse per command, noop otherwise
      ddr_cmd_valid_o <= pop;
      ddr_cmd_o       <= pop ? q_op : CMD_NOOP;
      if (ddr_cmd_valid_o) begin
        gap_cnt <= issued_gap;
      end else if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 1'b1;
      end
    end
  end

  // bank, address and tid only mean something with the valid pulse
  always_ff @(posedge clock) begin
    if (pop) begin
      ddr_ba_o  <= q_data_i[BA_LSB +: BANK_BITS];
      ddr_adr_o <= q_data_i[ADR_LSB +: ROW_BITS];
      ddr_tid_o <= q_data_i[TID_LSB +: TID_BITS];
    end
  end

  a_gap_honoured: assert property (@(posedge clock) disable iff (reset)
    ddr_cmd_valid_o |-> gap_cnt == '0);

endmodule

`default_nettype wire

/* verilog/ddr3_ctrl_top.sv */
`default_nettype none

module ddr3_ctrl_top (
  input  wire logic                           clock,
  input  wire logic                           reset,
  // write request port
  input  wire logic                           mem_wrreq_i,
  input  wire logic [ddr3_pkg::ADDR_BITS-1:0] mem_wradr_i,
  output logic                                mem_wrack_o,
  output logic [ddr3_pkg::TID_BITS-1:0]       mem_wrtid_o,
  // read request port
  input  wire logic                           mem_rdreq_i,
  input  wire logic [ddr3_pkg::ADDR_BITS-1:0] mem_rdadr_i,
  input  wire logic [ddr3_pkg::TID_BITS-1:0]  mem_rdtid_i,
  output logic                                mem_rdack_o,
  input  wire logic                           ref_tick_i,
  // memory command pins
  output logic                                ddr_cmd_valid_o,
  output ddr3_pkg::ddr3_cmd_e                 ddr_cmd_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]      ddr_ba_o,
  output logic [ddr3_pkg::ROW_BITS-1:0]       ddr_adr_o,
  output logic [ddr3_pkg::TID_BITS-1:0]       ddr_tid_o
);

  import ddr3_pkg::*;

  // scheduler into the queue
  logic                cmd_valid;
  logic                cmd_ready;
  logic [CMD_BITS-1:0] cmd_data;
  // queue into the timer
  logic                q_valid;
  logic                q_ready;
  logic [CMD_BITS-1:0] q_data;

  ddr3_scheduler u_sched (
    .clock       (clock),
    .reset       (reset),
    .mem_wrreq_i (mem_wrreq_i),
    .mem_wradr_i (mem_wradr_i),
    .mem_wrack_o (mem_wrack_o),
    .mem_wrtid_o (mem_wrtid_o),
    .mem_rdreq_i (mem_rdreq_i),
    .mem_rdadr_i (mem_rdadr_i),
    .mem_rdtid_i (mem_rdtid_i),
    .mem_rdack_o (mem_rdack_o),
    .ref_tick_i  (ref_tick_i),
    .cmd_valid_o (cmd_valid),
    .cmd_ready_i (cmd_ready),
    .cmd_data_o  (cmd_data)
  );

  // four commands of slack between scheduling and issue
  sync_fifo #(
    .WIDTH (CMD_BITS),
    .ABITS (2)
  ) u_cmd_fifo (
    .clock   (clock),
    .reset   (reset),
    .valid_i (cmd_valid),
    .ready_o (cmd_ready),
    .data_i  (cmd_data),
    .valid_o (q_valid),
    .ready_i (q_ready),
    .data_o  (q_data)
  );

  ddr3_cmd_timer u_timer (
    .clock           (clock),
    .reset           (reset),
    .q_valid_i       (q_valid),
    .q_ready_o       (q_ready),
    .q_data_i        (q_data),
    .ddr_cmd_valid_o (ddr_cmd_valid_o),
    .ddr_cmd_o       (ddr_cmd_o),
    .ddr_ba_o        (ddr_ba_o),
    .ddr_adr_o       (ddr_adr_o),
    .ddr_tid_o       (ddr_tid_o)
  );

endmodule

`default_nettype wire

/* verilog/ddr3_pkg.sv */
`default_nettype none

package ddr3_pkg;

  // address split is row, bank, column from msb down
  localparam int ROW_BITS = 13;
  localparam int BANK_BITS = 3;
  // only the burst-aligned upper column bits are carried
  localparam int COL_BITS = 7;
  localparam int ADDR_BITS = ROW_BITS + BANK_BITS + COL_BITS;
  localparam int TID_BITS = 4;
  localparam int NUM_BANKS = 1 << BANK_BITS;

  // packed command word is {op, bank, row or column, tid}
  localparam int OP_BITS = 3;
  localparam int CMD_BITS = OP_BITS + BANK_BITS + ROW_BITS + TID_BITS;
  localparam int TID_LSB = 0;
  localparam int ADR_LSB = TID_LSB + TID_BITS;
  localparam int BA_LSB = ADR_LSB + ROW_BITS;
  localparam int OP_LSB = BA_LSB + BANK_BITS;

  // A10 selects all banks on a precharge
  localparam int PREA_BIT = 10;

  // idle cycles the timer holds after each kind of command
  localparam int T_RP = 3;
  localparam int T_RCD = 3;
  localparam int T_CCD = 2;
  localparam int T_RFC = 12;
  localparam int GAP_BITS = 4;

  // encoded as {RAS#, CAS#, WE#} with CS# low
  typedef enum logic [OP_BITS-1:0] {
    CMD_NOOP = 3'b111,
    CMD_ZQCL = 3'b110,
    CMD_READ = 3'b101,
    CMD_WRIT = 3'b100,
    CMD_ACTV = 3'b011,
    CMD_PREC = 3'b010,
    CMD_REFR = 3'b001,
    CMD_MODE = 3'b000
  } ddr3_cmd_e;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_PREC,
    ST_ACTV,
    ST_ISSUE,
    ST_PREA,
    ST_REFR
  } sched_state_e;

endpackage

`default_nettype wire

/* verilog/ddr3_scheduler.sv */
`default_nettype none

module ddr3_scheduler (
  input  wire logic                             clock,
  input  wire logic                             reset,
  // write request port
  input  wire logic                             mem_wrreq_i,
  input  wire logic [ddr3_pkg::ADDR_BITS-1:0]   mem_wradr_i,
  output logic                                  mem_wrack_o,
  output logic [ddr3_pkg::TID_BITS-1:0]         mem_wrtid_o,
  // read request port
  input  wire logic                             mem_rdreq_i,
  input  wire logic [ddr3_pkg::ADDR_BITS-1:0]   mem_rdadr_i,
  input  wire logic [ddr3_pkg::TID_BITS-1:0]    mem_rdtid_i,
  output logic                                  mem_rdack_o,
  // one-cycle refresh request
  input  wire logic                             ref_tick_i,
  // command push towards the fifo
  output logic                                  cmd_valid_o,
  input  wire logic                             cmd_ready_i,
  output logic [ddr3_pkg::CMD_BITS-1:0]         cmd_data_o
);

  import ddr3_pkg::*;

  sched_state_e state;

  // open-row table
  logic [NUM_BANKS-1:0] bank_open;
  logic [ROW_BITS-1:0]  open_row [NUM_BANKS];

  logic                ref_pend;
  logic                prefer_rd;
  logic [TID_BITS-1:0] wr_cnt;
  logic                rd_ack_q;
  logic                wr_ack_q;

  // request being served, held for the whole command sequence
  logic                 req_is_wr;
  logic [ROW_BITS-1:0]  req_row;
  logic [BANK_BITS-1:0] req_bank;
  logic [COL_BITS-1:0]  req_col;
  logic [TID_BITS-1:0]  req_tid;

  logic                 rd_elig;
  logic                 wr_elig;
  logic                 pick_rd;
  logic                 pick_wr;
  logic                 start_req;
  logic [ADDR_BITS-1:0] sel_adr;
  logic [ROW_BITS-1:0]  sel_row;
  logic [BANK_BITS-1:0] sel_bank;
  logic [COL_BITS-1:0]  sel_col;

  logic                 push;
  ddr3_cmd_e            cmd_op;
  logic [BANK_BITS-1:0] cmd_ba;
  logic [ROW_BITS-1:0]  cmd_adr;
  logic [TID_BITS-1:0]  cmd_tid;

  // a port is served again only once its handshake has closed
  // and no other ack is still open
  assign rd_elig = mem_rdreq_i && !rd_ack_q && !wr_ack_q;
  assign wr_elig = mem_wrreq_i && !rd_ack_q && !wr_ack_q;

  // fairness bit breaks the tie when both ports ask
  assign pick_rd = rd_elig && (!wr_elig || prefer_rd);
  assign pick_wr = wr_elig && !pick_rd;

  // refresh beats any request in idle
  assign start_req = (state == ST_IDLE) && !ref_pend && (pick_rd || pick_wr);

  assign sel_adr  = pick_wr ? mem_wradr_i : mem_rdadr_i;
  assign sel_row  = sel_adr[ADDR_BITS-1 -: ROW_BITS];
  assign sel_bank = sel_adr[COL_BITS +: BANK_BITS];
  assign sel_col  = sel_adr[COL_BITS-1:0];

  assign push = cmd_valid_o && cmd_ready_i;

  // every non-idle state offers exactly one command
  always_comb begin
    cmd_valid_o = 1'b1;
    cmd_op      = CMD_NOOP;
    cmd_ba      = req_bank;
    cmd_adr     = '0;
    cmd_tid     = req_tid;
    case (state)
      ST_PREC: begin
        cmd_op = CMD_PREC;
      end
      ST_ACTV: begin
        cmd_op  = CMD_ACTV;
        cmd_adr = req_row;
      end
      ST_ISSUE: begin
        cmd_op  = req_is_wr ? CMD_WRIT : CMD_READ;
        cmd_adr = ROW_BITS'(req_col);
      end
      ST_PREA: begin
        cmd_op            = CMD_PREC;
        cmd_ba            = '0;
        cmd_adr[PREA_BIT] = 1'b1;
        cmd_tid           = '0;
      end
      ST_REFR: begin
        cmd_op  = CMD_REFR;
        cmd_ba  = '0;
        cmd_tid = '0;
      end
      default: begin
        cmd_valid_o = 1'b0;
      end
    endcase
  end

  assign cmd_data_o = {cmd_op, cmd_ba, cmd_adr, cmd_tid};

  // state moves only when the fifo takes the command
  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= ST_IDLE;
      bank_open <= '0;
      prefer_rd <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (ref_pend) begin
            state <= (|bank_open) ? ST_PREA : ST_REFR;
          end else if (start_req) begin
            // the bit only flips when both ports contend
            if (rd_elig && wr_elig) begin
              prefer_rd <= !prefer_rd;
            end
            if (!bank_open[sel_bank]) begin
              state <= ST_ACTV;
            end else if (open_row[sel_bank] != sel_row) begin
              state <= ST_PREC;
            end else begin
              state <= ST_ISSUE;
            end
          end
        end
        ST_PREC: begin
          if (push) begin
            bank_open[req_bank] <= 1'b0;
            state               <= ST_ACTV;
          end
        end
        ST_ACTV: begin
          if (push) begin
            bank_open[req_bank] <= 1'b1;
            state               <= ST_ISSUE;
          end
        end
        ST_ISSUE: begin
          if (push) begin
            state <= ST_IDLE;
          end
        end
        ST_PREA: begin
          // every bank closes together
          if (push) begin
            bank_open <= '0;
            state     <= ST_REFR;
          end
        end
        ST_REFR: begin
          if (push) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // latch the chosen request and the row it opens
  always_ff @(posedge clock) begin
    if (start_req) begin
      req_is_wr <= pick_wr;
      req_row   <= sel_row;
      req_bank  <= sel_bank;
      req_col   <= sel_col;
      req_tid   <= pick_wr ? wr_cnt : mem_rdtid_i;
    end
    if (state == ST_ACTV && push) begin
      open_row[req_bank] <= req_row;
    end
  end

  // sticky until the refresh command is pushed
  always_ff @(posedge clock) begin
    if (reset) begin
      ref_pend <= 1'b0;
    end else if (ref_tick_i) begin
      ref_pend <= 1'b1;
    end else if (state == ST_REFR && push) begin
      ref_pend <= 1'b0;
    end
  end

  // acks rise after the read/write push and fall one cycle after req
  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ack_q <= 1'b0;
      wr_ack_q <= 1'b0;
      wr_cnt   <= '0;
    end else begin
      if (state == ST_ISSUE && push && !req_is_wr) begin
        rd_ack_q <= 1'b1;
      end else if (!mem_rdreq_i) begin
        rd_ack_q <= 1'b0;
      end
      if (state == ST_ISSUE && push && req_is_wr) begin
        wr_ack_q <= 1'b1;
      end else if (!mem_wrreq_i) begin
        wr_ack_q <= 1'b0;
      end
      // write id moves on as the handshake closes
      if (wr_ack_q && !mem_wrreq_i) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
    end
  end

  assign mem_rdack_o = rd_ack_q;
  assign mem_wrack_o = wr_ack_q;
  // still the id of the acked write while ack is high
  assign mem_wrtid_o = wr_cnt;

  // an ack is only raised while its req is held
  a_rdack_needs_req: assert property (@(posedge clock) disable iff (reset)
    $rose(mem_rdack_o) |-> $past(mem_rdreq_i));
  a_wrack_needs_req: assert property (@(posedge clock) disable iff (reset)
    $rose(mem_wrack_o) |-> $past(mem_wrreq_i));
  a_one_ack: assert property (@(posedge clock) disable iff (reset)
    !(mem_rdack_o && mem_wrack_o));

endmodule

`default_nettype wire

/* verilog/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int ABITS = 2
) (
  input  wire logic             clock,
  input  wire logic             reset,
  input  wire logic             valid_i,
  output logic                  ready_o,
  input  wire logic [WIDTH-1:0] data_i,
  output logic                  valid_o,
  input  wire logic             ready_i,
  output logic [WIDTH-1:0]      data_o
);

  localparam int DEPTH = 1 << ABITS;

  logic [WIDTH-1:0] mem [DEPTH];
  // one extra bit tells full from empty
  logic [ABITS:0]   wr_ptr;
  logic [ABITS:0]   rd_ptr;
  logic [ABITS:0]   fill;
  logic             push;
  logic             load;
  logic             bypass;

  assign fill    = wr_ptr - rd_ptr;
  assign ready_o = (fill != (ABITS + 1)'(DEPTH));
  assign push    = valid_i && ready_o;

  // output register is free or being drained this cycle
  assign load = !valid_o || ready_i;

  // empty buffer sends the word straight to the output register
  assign bypass = load && (fill == '0) && push;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      valid_o <= 1'b0;
    end else begin
      if (push && !bypass) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (load && fill != '0) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (load) begin
        valid_o <= (fill != '0) || push;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push && !bypass) begin
      mem[wr_ptr[ABITS-1:0]] <= data_i;
    end
    // oldest stored word goes first
    if (load) begin
      if (fill != '0) begin
        data_o <= mem[rd_ptr[ABITS-1:0]];
      end else if (push) begin
        data_o <= data_i;
      end
    end
  end

  // stored words never outgrow the buffer
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    fill <= (ABITS + 1)'(DEPTH));
  a_no_phantom: assert property (@(posedge clock) disable iff (reset)
    $rose(valid_o) |-> $past(push || fill != '0));

endmodule

`default_nettype wire
